// ==== source/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Datapath widths
`define CSR_XLEN    32
`define CSR_ADDR_W  12
`define CSR_TAG_W   4                 // Instruction tag from the core
`define CSR_CNT_W   64                // cycle, mtime and mtimecmp

// mcause codes
`define CSR_CAUSE_MTI      32'h8000_0007   // Interrupt bit plus code 7
`define CSR_CAUSE_ECALL_U  32'd8           // ECALL from U, add the mode for M

// MXL=1, extensions I, M and A
`define CSR_MISA_VALUE  32'h4000_1101

// mstatus fields
`define CSR_MSTATUS_MIE_BIT   3
`define CSR_MSTATUS_MPIE_BIT  7
`define CSR_MSTATUS_MPP_LO    11      // MPP sits in bits 12:11

// Timer bit, same spot in mie and mip
`define CSR_MTIP_BIT  7

`endif

// ==== source/csr_pkg.sv ====
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    // Only U and M are implemented
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        M_MODE = 2'd3
    } priv_mode_e;

    // Bit 2 marks the two-cycle trap commands
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,             // No CSR access
        CSR_W     = 3'd1,             // csrrw
        CSR_S     = 3'd2,             // csrrs
        CSR_C     = 3'd3,             // csrrc
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        ADDR_MSTATUS  = 12'h300,
        ADDR_MISA     = 12'h301,      // Read as constant
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MIP      = 12'h344,      // Read-only here
        ADDR_MCYCLE   = 12'hb00,
        ADDR_MCYCLEH  = 12'hb80,
        ADDR_CYCLE    = 12'hc00,      // User view of the counter
        ADDR_CYCLEH   = 12'hc80
    } csr_addr_e;

endpackage

`default_nettype wire

// ==== source/csr_decode.sv ====
`default_nettype none

`include "csr_cfg.svh"

module csr_decode (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       csr_valid,
    input  wire [`CSR_TAG_W-1:0]      csr_tag,
    input  wire csr_pkg::csr_cmd_e    csr_cmd,
    input  wire [`CSR_ADDR_W-1:0]     csr_addr,
    input  wire csr_pkg::priv_mode_e  cur_mode,
    output logic                      csr_stall,
    output logic                      commit,
    output logic                      is_write,
    output logic                      is_ecall,
    output logic                      is_mret,
    output logic                      can_read,
    output logic                      wr_en
);
    import csr_pkg::*;

    logic [`CSR_TAG_W-1:0] saved_tag;     // Tag of the last valid cycle
    logic                  tag_seen;      // saved_tag holds a real tag
    logic                  is_trap_cmd;
    logic                  new_tag;
    logic                  can_write;

    // Command decode
    assign is_write    = (csr_cmd == CSR_W) || (csr_cmd == CSR_S) || (csr_cmd == CSR_C);
    assign is_ecall    = (csr_cmd == CSR_ECALL);
    assign is_mret     = (csr_cmd == CSR_MRET);
    assign is_trap_cmd = csr_cmd[2];

    // First sight of a trap command stalls, the repeat goes through
    assign new_tag   = !tag_seen || (csr_tag != saved_tag);
    assign csr_stall = csr_valid && is_trap_cmd && new_tag;
    assign commit    = csr_valid && !csr_stall;

    // Privilege rule from address bits 9:8, bits 11:10 == 3 is read-only
    assign can_read  = (csr_addr[9:8] <= cur_mode);
    assign can_write = can_read && (csr_addr[11:10] != 2'b11);
    assign wr_en     = commit && is_write && can_write;

    always_ff @(posedge clk) begin
        if (csr_valid)
            saved_tag <= csr_tag;     // Held steady by the core during stall
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tag_seen <= 1'b0;
        else if (csr_valid)
            tag_seen <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/csr_trap.sv ====
`default_nettype none

`include "csr_cfg.svh"

module csr_trap (
    input  wire                       commit,
    input  wire                       is_ecall,
    input  wire                       is_mret,
    input  wire csr_pkg::priv_mode_e  cur_mode,
    input  wire                       mstatus_mie,
    input  wire                       mie_mtie,
    input  wire                       mip_mtip,
    input  wire [`CSR_XLEN-1:0]       mtvec,
    input  wire [`CSR_XLEN-1:0]       mepc,
    output logic                      trap_take,
    output logic                      trap_is_ret,
    output logic [`CSR_XLEN-1:0]      trap_cause,
    output logic                      csr_trap,
    output logic [`CSR_XLEN-1:0]      csr_trap_vector
);
    import csr_pkg::*;

    localparam logic [1:0] TVEC_VECTORED = 2'b01;

    logic                 irq_pend;
    logic                 tvec_vectored;
    logic [`CSR_XLEN-1:0] ecall_cause;
    logic [`CSR_XLEN-1:0] tvec_base;
    logic [`CSR_XLEN-1:0] tvec_offset;

    // Global enable is implied below M, MIE gates it in M
    assign irq_pend = mie_mtie && mip_mtip && ((cur_mode == U_MODE) || mstatus_mie);

    // 8 from U, 11 from M
    assign ecall_cause = `CSR_CAUSE_ECALL_U + {{(`CSR_XLEN-2){1'b0}}, cur_mode};

    // ECALL wins over the timer interrupt
    assign trap_cause = is_ecall ? ecall_cause : `CSR_CAUSE_MTI;

    // A pending interrupt preempts an MRET in the same cycle
    assign trap_take   = commit && (is_ecall || irq_pend);
    assign trap_is_ret = commit && is_mret && !irq_pend;
    assign csr_trap    = trap_take || trap_is_ret;

    assign tvec_base     = {mtvec[`CSR_XLEN-1:2], 2'b00};   // Mode bits dropped
    assign tvec_vectored = (mtvec[1:0] == TVEC_VECTORED);
    assign tvec_offset   = {trap_cause[`CSR_XLEN-3:0], 2'b00};  // 4 * code, ignores bit 31

    always_comb begin
        if (trap_is_ret)
            csr_trap_vector = mepc;
        else if (!is_ecall && tvec_vectored)
            csr_trap_vector = tvec_base + tvec_offset;     // Interrupt, vectored
        else
            csr_trap_vector = tvec_base;                   // Exceptions always direct
    end

endmodule

`default_nettype wire

// ==== source/csr_regs.sv ====
`default_nettype none

`include "csr_cfg.svh"

module csr_regs (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       commit,
    input  wire                       is_write,
    input  wire                       trap_take,
    input  wire                       trap_is_ret,
    input  wire [`CSR_XLEN-1:0]       trap_cause,
    input  wire                       wr_en,
    input  wire [`CSR_ADDR_W-1:0]     csr_addr,
    input  wire [`CSR_XLEN-1:0]       wdata,
    input  wire [`CSR_XLEN-1:0]       csr_pc,
    input  wire [`CSR_CNT_W-1:0]      mtime,
    input  wire [`CSR_CNT_W-1:0]      mtimecmp,
    output csr_pkg::priv_mode_e       cur_mode,
    output logic                      mstatus_mie,
    output logic                      mstatus_mpie,
    output csr_pkg::priv_mode_e       mstatus_mpp,
    output logic                      mie_mtie,
    output logic                      mip_mtip,
    output logic [`CSR_XLEN-1:0]      mtvec,
    output logic [`CSR_XLEN-1:0]      mscratch,
    output logic [`CSR_XLEN-1:0]      mepc,
    output logic [`CSR_XLEN-1:0]      mcause
);
    import csr_pkg::*;

    logic do_write;
    logic mpp_is_u;

    // Trap or return in the same cycle swallows the write
    assign do_write = is_write && wr_en && !trap_take;

    // MPP is WARL, anything but U becomes M
    assign mpp_is_u = (wdata[`CSR_MSTATUS_MPP_LO +: 2] == U_MODE);

    // Timer pending, one cycle behind the compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mip_mtip <= 1'b0;
        else
            mip_mtip <= (mtime >= mtimecmp);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_mode     <= M_MODE;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= M_MODE;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (commit) begin
            if (trap_take) begin
                // Push the interrupt enable and mode stack
                cur_mode     <= M_MODE;
                mcause       <= trap_cause;
                mepc         <= csr_pc;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= cur_mode;
            end else if (trap_is_ret) begin
                // Pop it, least privileged mode left in MPP
                mstatus_mie  <= mstatus_mpie;
                cur_mode     <= mstatus_mpp;
                mstatus_mpie <= 1'b1;
                mstatus_mpp  <= U_MODE;
            end else if (do_write) begin
                case (csr_addr)
                    ADDR_MSTATUS: begin
                        mstatus_mie  <= wdata[`CSR_MSTATUS_MIE_BIT];
                        mstatus_mpie <= wdata[`CSR_MSTATUS_MPIE_BIT];
                        mstatus_mpp  <= mpp_is_u ? U_MODE : M_MODE;
                    end
                    ADDR_MIE:      mie_mtie <= wdata[`CSR_MTIP_BIT];   // Only MTIE kept
                    ADDR_MTVEC:    mtvec    <= wdata;
                    ADDR_MSCRATCH: mscratch <= wdata;
                    ADDR_MEPC:     mepc     <= {wdata[`CSR_XLEN-1:2], 2'b00};  // Word aligned
                    ADDR_MCAUSE:   mcause   <= wdata;
                    default: ;     // misa, mip and counters ignore writes
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/csr_read.sv ====
`default_nettype none

`include "csr_cfg.svh"

module csr_read (
    input  wire                       csr_pkg::csr_cmd_e csr_cmd,
    input  wire [`CSR_ADDR_W-1:0]     csr_addr,
    input  wire [`CSR_XLEN-1:0]       csr_op1,
    input  wire                       can_read,
    input  wire [`CSR_CNT_W-1:0]      cycle_count,
    input  wire                       mstatus_mie,
    input  wire                       mstatus_mpie,
    input  wire csr_pkg::priv_mode_e  mstatus_mpp,
    input  wire                       mie_mtie,
    input  wire                       mip_mtip,
    input  wire [`CSR_XLEN-1:0]       mtvec,
    input  wire [`CSR_XLEN-1:0]       mscratch,
    input  wire [`CSR_XLEN-1:0]       mepc,
    input  wire [`CSR_XLEN-1:0]       mcause,
    output logic [`CSR_XLEN-1:0]      csr_rdata,
    output logic [`CSR_XLEN-1:0]      wdata
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] mstatus_val;
    logic [`CSR_XLEN-1:0] mie_val;
    logic [`CSR_XLEN-1:0] mip_val;
    logic [`CSR_XLEN-1:0] rdata_raw;

    // Rebuild the full registers from the kept fields
    always_comb begin
        mstatus_val = '0;
        mstatus_val[`CSR_MSTATUS_MIE_BIT]    = mstatus_mie;
        mstatus_val[`CSR_MSTATUS_MPIE_BIT]   = mstatus_mpie;
        mstatus_val[`CSR_MSTATUS_MPP_LO +: 2] = mstatus_mpp;
        mie_val = '0;
        mie_val[`CSR_MTIP_BIT] = mie_mtie;
        mip_val = '0;
        mip_val[`CSR_MTIP_BIT] = mip_mtip;
    end

    always_comb begin
        case (csr_addr)
            ADDR_MSTATUS:              rdata_raw = mstatus_val;
            ADDR_MISA:                 rdata_raw = `CSR_MISA_VALUE;
            ADDR_MIE:                  rdata_raw = mie_val;
            ADDR_MTVEC:                rdata_raw = mtvec;
            ADDR_MSCRATCH:             rdata_raw = mscratch;
            ADDR_MEPC:                 rdata_raw = mepc;
            ADDR_MCAUSE:               rdata_raw = mcause;
            ADDR_MIP:                  rdata_raw = mip_val;
            ADDR_MCYCLE, ADDR_CYCLE:   rdata_raw = cycle_count[`CSR_XLEN-1:0];
            ADDR_MCYCLEH, ADDR_CYCLEH: rdata_raw = cycle_count[`CSR_CNT_W-1:`CSR_XLEN];
            default:                   rdata_raw = '0;     // Unimplemented reads zero
        endcase
    end

    assign csr_rdata = can_read ? rdata_raw : '0;     // Too privileged reads zero

    // Read-modify-write value for the set and clear forms
    always_comb begin
        case (csr_cmd)
            CSR_W:   wdata = csr_op1;
            CSR_S:   wdata = csr_rdata | csr_op1;
            CSR_C:   wdata = csr_rdata & ~csr_op1;
            default: wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/csr_unit.sv ====
`default_nettype none

`include "csr_cfg.svh"

module csr_unit (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       csr_valid,
    input  wire [`CSR_TAG_W-1:0]      csr_tag,
    input  wire csr_pkg::csr_cmd_e    csr_cmd,
    input  wire [`CSR_ADDR_W-1:0]     csr_addr,
    input  wire [`CSR_XLEN-1:0]       csr_pc,
    input  wire [`CSR_XLEN-1:0]       csr_op1,
    input  wire [`CSR_CNT_W-1:0]      cycle_count,
    input  wire [`CSR_CNT_W-1:0]      mtime,
    input  wire [`CSR_CNT_W-1:0]      mtimecmp,
    output wire [`CSR_XLEN-1:0]       csr_rdata,
    output wire                       csr_stall,
    output wire                       csr_trap,
    output wire [`CSR_XLEN-1:0]       csr_trap_vector,
    output wire csr_pkg::priv_mode_e  priv_mode
);
    import csr_pkg::*;

    // Decode to processing
    wire commit, is_write, is_ecall, is_mret, can_read, wr_en;
    // Trap decision
    wire                 trap_take, trap_is_ret;
    wire [`CSR_XLEN-1:0] trap_cause;
    // Architectural state
    wire                 mstatus_mie, mstatus_mpie, mie_mtie, mip_mtip;
    wire priv_mode_e     mstatus_mpp;
    wire [`CSR_XLEN-1:0] mtvec, mscratch, mepc, mcause;
    wire [`CSR_XLEN-1:0] wdata;

    csr_decode u_decode (
        .clk(clk), .rst_n(rst_n), .csr_valid(csr_valid), .csr_tag(csr_tag),
        .csr_cmd(csr_cmd), .csr_addr(csr_addr), .cur_mode(priv_mode),
        .csr_stall(csr_stall), .commit(commit), .is_write(is_write),
        .is_ecall(is_ecall), .is_mret(is_mret), .can_read(can_read), .wr_en(wr_en)
    );

    csr_trap u_trap (
        .commit(commit), .is_ecall(is_ecall), .is_mret(is_mret), .cur_mode(priv_mode),
        .mstatus_mie(mstatus_mie), .mie_mtie(mie_mtie), .mip_mtip(mip_mtip),
        .mtvec(mtvec), .mepc(mepc), .trap_take(trap_take), .trap_is_ret(trap_is_ret),
        .trap_cause(trap_cause), .csr_trap(csr_trap), .csr_trap_vector(csr_trap_vector)
    );

    csr_regs u_regs (
        .clk(clk), .rst_n(rst_n), .commit(commit), .is_write(is_write),
        .trap_take(trap_take), .trap_is_ret(trap_is_ret), .trap_cause(trap_cause),
        .wr_en(wr_en), .csr_addr(csr_addr), .wdata(wdata), .csr_pc(csr_pc),
        .mtime(mtime), .mtimecmp(mtimecmp), .cur_mode(priv_mode),
        .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie), .mstatus_mpp(mstatus_mpp),
        .mie_mtie(mie_mtie), .mip_mtip(mip_mtip), .mtvec(mtvec), .mscratch(mscratch),
        .mepc(mepc), .mcause(mcause)
    );

    csr_read u_read (
        .csr_cmd(csr_cmd), .csr_addr(csr_addr), .csr_op1(csr_op1), .can_read(can_read),
        .cycle_count(cycle_count), .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie),
        .mstatus_mpp(mstatus_mpp), .mie_mtie(mie_mtie), .mip_mtip(mip_mtip),
        .mtvec(mtvec), .mscratch(mscratch), .mepc(mepc), .mcause(mcause),
        .csr_rdata(csr_rdata), .wdata(wdata)
    );

endmodule

`default_nettype wire

// ==== tests/csr_unit_asserts.sv ====
`default_nettype none

module csr_unit_asserts (
    input wire                      clk,
    input wire                      rst_n,
    input wire                      csr_valid,
    input wire                      csr_stall,
    input wire                      csr_trap,
    input wire csr_pkg::priv_mode_e priv_mode
);
    import csr_pkg::*;

    int fail_count = 0;     // Failed properties so far

    // Stall only answers a valid request
    stall_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        csr_stall |-> csr_valid)
        else begin
            fail_count++;
            $error("csr_stall without csr_valid");
        end

    // Stall cycle and trap cycle are distinct
    stall_trap_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(csr_stall && csr_trap))
        else begin
            fail_count++;
            $error("csr_stall and csr_trap both high");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!csr_stall && !csr_trap))
        else begin
            fail_count++;
            $error("handshake active in reset");
        end

    // Only U and M exist
    legal_mode: assert property (@(posedge clk) disable iff (!rst_n)
        (priv_mode == U_MODE) || (priv_mode == M_MODE))
        else begin
            fail_count++;
            $error("illegal priv_mode");
        end

endmodule

bind csr_unit csr_unit_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .csr_valid(csr_valid),
    .csr_stall(csr_stall), .csr_trap(csr_trap), .priv_mode(priv_mode)
);

`default_nettype wire

// ==== tests/csr_unit_tb.sv ====
`default_nettype none

`include "csr_cfg.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam int MAX_CYCLES = 2000;   // ~400 instructions, 3 cycles worst case, plus reset

    logic                   clk;
    logic                   rst_n;
    logic                   csr_valid;
    logic [`CSR_TAG_W-1:0]  csr_tag;
    csr_cmd_e               csr_cmd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`CSR_XLEN-1:0]   csr_pc;
    logic [`CSR_XLEN-1:0]   csr_op1;
    logic [`CSR_CNT_W-1:0]  cycle_count;
    logic [`CSR_CNT_W-1:0]  mtime;
    logic [`CSR_CNT_W-1:0]  mtimecmp;
    wire  [`CSR_XLEN-1:0]   csr_rdata;
    wire                    csr_stall;
    wire                    csr_trap;
    wire  [`CSR_XLEN-1:0]   csr_trap_vector;
    priv_mode_e             priv_mode;

    // Reference model state
    priv_mode_e           m_mode;
    priv_mode_e           m_mpp;
    logic                 m_mie, m_mpie, m_mtie, m_mtip;
    logic [`CSR_XLEN-1:0] m_mtvec, m_mscratch, m_mepc, m_mcause;

    logic [31:0] lfsr;
    logic        timer_hit;          // Drive mtime past mtimecmp
    int          cycle_cnt;
    logic [11:0] wr_addrs [5];
    logic [11:0] all_addrs [12];

    csr_unit dut0 (
        .clk(clk), .rst_n(rst_n), .csr_valid(csr_valid), .csr_tag(csr_tag),
        .csr_cmd(csr_cmd), .csr_addr(csr_addr), .csr_pc(csr_pc), .csr_op1(csr_op1),
        .cycle_count(cycle_count), .mtime(mtime), .mtimecmp(mtimecmp),
        .csr_rdata(csr_rdata), .csr_stall(csr_stall), .csr_trap(csr_trap),
        .csr_trap_vector(csr_trap_vector), .priv_mode(priv_mode)
    );

    always #2 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);        // One step per bit taken
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic report_fail(input string msg);
        $display("FAIL at time %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(input string what, input logic [`CSR_XLEN-1:0] got,
                              input logic [`CSR_XLEN-1:0] exp);
        if (got !== exp)
            report_fail($sformatf("%s got %08h expected %08h", what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_fail($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_mode(input priv_mode_e got, input priv_mode_e exp);
        if (got !== exp)
            report_fail($sformatf("priv_mode got %0d expected %0d", got, exp));
    endtask

    // Readable when address bits 9:8 do not exceed the mode
    function automatic logic [31:0] model_read(input logic [11:0] addr);
        logic [31:0] v;
        v = '0;
        if (addr[9:8] > m_mode)
            return '0;
        case (addr)
            ADDR_MSTATUS: begin
                v[3] = m_mie;
                v[7] = m_mpie;
                v[12:11] = m_mpp;
            end
            ADDR_MISA:     v = `CSR_MISA_VALUE;
            ADDR_MIE:      v[7] = m_mtie;
            ADDR_MTVEC:    v = m_mtvec;
            ADDR_MSCRATCH: v = m_mscratch;
            ADDR_MEPC:     v = m_mepc;
            ADDR_MCAUSE:   v = m_mcause;
            ADDR_MIP:      v[7] = m_mtip;
            ADDR_MCYCLE, ADDR_CYCLE:   v = cycle_count[31:0];
            ADDR_MCYCLEH, ADDR_CYCLEH: v = cycle_count[63:32];
            default:       v = '0;
        endcase
        return v;
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] wd);
        case (addr)
            ADDR_MSTATUS: begin
                m_mie  = wd[3];
                m_mpie = wd[7];
                m_mpp  = (wd[12:11] == 2'b00) ? U_MODE : M_MODE;  // Non-U stores M
            end
            ADDR_MIE:      m_mtie = wd[7];
            ADDR_MTVEC:    m_mtvec = wd;
            ADDR_MSCRATCH: m_mscratch = wd;
            ADDR_MEPC:     m_mepc = {wd[31:2], 2'b00};
            ADDR_MCAUSE:   m_mcause = wd;
            default: ;
        endcase
    endtask

    // One instruction through the handshake, checked against the model
    task automatic do_instr(input csr_cmd_e cmd, input logic [11:0] addr,
                            input logic [31:0] op1);
        logic        irq;
        logic        is_trap_cmd;
        logic        wr_ok;
        logic [31:0] rd;
        logic [31:0] wd;
        logic [31:0] base;
        logic [31:0] vec;
        @(negedge clk);
        csr_valid   = 1'b1;
        csr_tag     = csr_tag + 1'b1;     // New tag for every instruction
        csr_cmd     = cmd;
        csr_addr    = addr;
        csr_op1     = op1;
        csr_pc      = rand_bits(30) << 2;
        cycle_count = {rand_bits(32), rand_bits(32)};
        mtime       = timer_hit ? 64'd100 : 64'd10;
        mtimecmp    = 64'd50;
        is_trap_cmd = (cmd == CSR_ECALL) || (cmd == CSR_MRET);
        #1;
        check_mode(priv_mode, m_mode);
        if (is_trap_cmd) begin
            check_bit("csr_stall on first trap cycle", csr_stall, 1'b1);
            check_bit("csr_trap on stall cycle", csr_trap, 1'b0);
            @(posedge clk);
            m_mtip = (mtime >= mtimecmp);
            @(negedge clk);              // Inputs held through the stall
            #1;
        end
        check_bit("csr_stall", csr_stall, 1'b0);
        irq = m_mtie && m_mtip && ((m_mode == U_MODE) || m_mie);
        rd  = model_read(addr);
        check_word("csr_rdata", csr_rdata, rd);
        check_bit("csr_trap", csr_trap, is_trap_cmd || irq);
        base = {m_mtvec[31:2], 2'b00};
        if ((cmd == CSR_MRET) && !irq)
            vec = m_mepc;
        else if (cmd == CSR_ECALL)
            vec = base;
        else
            vec = (m_mtvec[1:0] == 2'b01) ? base + 32'd28 : base;   // Timer code 7
        if (is_trap_cmd || irq)
            check_word("csr_trap_vector", csr_trap_vector, vec);
        wr_ok = (addr[9:8] <= m_mode) && (addr[11:10] != 2'b11);
        if ((cmd == CSR_ECALL) || irq) begin
            m_mcause = (cmd == CSR_ECALL) ? 32'd8 + {30'd0, m_mode} : `CSR_CAUSE_MTI;
            m_mepc   = csr_pc;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mpp    = m_mode;
            m_mode   = M_MODE;
        end else if (cmd == CSR_MRET) begin
            m_mie  = m_mpie;
            m_mode = m_mpp;
            m_mpie = 1'b1;
            m_mpp  = U_MODE;
        end else if (wr_ok && (cmd == CSR_W || cmd == CSR_S || cmd == CSR_C)) begin
            if (cmd == CSR_W)
                wd = op1;
            else if (cmd == CSR_S)
                wd = rd | op1;
            else
                wd = rd & ~op1;
            model_write(addr, wd);
        end
        @(posedge clk);
        m_mtip = (mtime >= mtimecmp);     // Compare registered at every edge
    endtask

    function automatic csr_cmd_e rand_rw_cmd();
        logic [2:0] c;
        c = 3'(rand_bits(2) % 3) + 3'd1;  // W, S or C
        return csr_cmd_e'(c);
    endfunction

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        csr_valid = 1'b0;
        csr_tag = '0;
        csr_cmd = CSR_X;
        csr_addr = '0;
        csr_pc = '0;
        csr_op1 = '0;
        cycle_count = '0;
        mtime = 64'd10;
        mtimecmp = 64'd50;
        timer_hit = 1'b0;
        cycle_cnt = 0;
        lfsr = 32'd7;
        wr_addrs = '{ADDR_MSCRATCH, ADDR_MTVEC, ADDR_MEPC, ADDR_MIE, ADDR_MSTATUS};
        all_addrs = '{ADDR_MSTATUS, ADDR_MISA, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH,
                      ADDR_MEPC, ADDR_MCAUSE, ADDR_MIP, ADDR_MCYCLE, ADDR_MCYCLEH,
                      ADDR_CYCLE, ADDR_CYCLEH};
        // Reset values, MPP=M gives mstatus 0x1800
        m_mode = M_MODE;
        m_mpp = M_MODE;
        m_mie = 1'b0;
        m_mpie = 1'b0;
        m_mtie = 1'b0;
        m_mtip = 1'b0;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset state of every CSR
        foreach (all_addrs[i])
            do_instr(CSR_X, all_addrs[i], 32'd0);

        // Random read-modify-write in M mode
        repeat (150)
            do_instr(rand_rw_cmd(), wr_addrs[3'(rand_bits(3) % 5)], rand_bits(32));

        // Counter addresses never store
        do_instr(CSR_W, ADDR_MCYCLE, 32'hffff_ffff);
        do_instr(CSR_S, ADDR_MCYCLEH, 32'hffff_ffff);
        do_instr(CSR_W, ADDR_CYCLE, 32'h1234_5678);

        // ECALL from M, then drop to U through MRET
        do_instr(CSR_ECALL, ADDR_MSTATUS, 32'd0);
        do_instr(CSR_W, ADDR_MSTATUS, 32'd0);
        do_instr(CSR_MRET, ADDR_MSTATUS, 32'd0);
        repeat (40)
            do_instr(rand_rw_cmd(), all_addrs[4'(rand_bits(4) % 12)], rand_bits(32));
        do_instr(CSR_ECALL, ADDR_CYCLE, 32'd0);      // Cause 8, back to M
        do_instr(CSR_MRET, ADDR_CYCLE, 32'd0);
        do_instr(CSR_ECALL, ADDR_CYCLE, 32'd0);

        // Timer interrupt with vectored mtvec
        do_instr(CSR_W, ADDR_MTVEC, 32'h0000_0101);
        do_instr(CSR_W, ADDR_MIE, 32'h0000_0080);
        do_instr(CSR_W, ADDR_MSTATUS, 32'h0000_0008);
        timer_hit = 1'b1;
        do_instr(CSR_X, ADDR_MSCRATCH, 32'd0);       // MTIP rises at this edge
        do_instr(CSR_X, ADDR_MSCRATCH, 32'd0);       // Takes the interrupt
        timer_hit = 1'b0;
        do_instr(CSR_MRET, ADDR_MSCRATCH, 32'd0);

        // Mixed traffic with a toggling timer
        repeat (180) begin
            timer_hit = (rand_bits(2) == 32'd0);
            do_instr(csr_cmd_e'(3'(rand_bits(3) % 6)), all_addrs[4'(rand_bits(4) % 12)],
                     rand_bits(32));
        end

        @(negedge clk);
        csr_valid = 1'b0;
        if (dut0.u_asserts.fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_unit.f ====
+incdir+source
source/csr_pkg.sv
source/csr_decode.sv
source/csr_trap.sv
source/csr_regs.sv
source/csr_read.sv
source/csr_unit.sv
tests/csr_unit_asserts.sv
tests/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f csr_unit.f --top-module csr_unit_tb \
    --Mdir obj_dir -o csr_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/csr_unit_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
